//--- include/lcdTiming_defs.svh
`ifndef LCD_TIMING_DEFS_SVH
`define LCD_TIMING_DEFS_SVH

////////////////////
// Step counter sizing
`define LCD_TIMER_WIDTH 20 // Holds the power-up wait
`define LCD_STEP_WIDTH 4 // Index into the init table
`define LCD_INIT_STEPS 13 // Power-up wait plus twelve nibbles

////////////////////
// Bus timing, all in clock cycles

// Enable high time of every write
`define LCD_PULSE_CYCLES 15

// Step 0, no pulse
`define LCD_POWERUP_CYCLES 750000

// Wake-up nibbles, whole step lengths
`define LCD_INIT_WAIT1_CYCLES 205015
`define LCD_INIT_WAIT2_CYCLES 5015
`define LCD_INIT_WAIT3_CYCLES 2015 // Used by steps 3 and 4

// High nibble of any byte, short gap before the low one
`define LCD_NIBBLE_GAP_CYCLES 75

// Low nibble of an ordinary command
`define LCD_CMD_CYCLES 2065

// Clear command and every data byte
`define LCD_SLOW_CYCLES 82515

`endif

//--- src/lcdPkg.sv
`default_nettype none

package lcdPkg;

	////////////////////
	// Sequencer state
	typedef enum logic [1:0]
	{
		Init, // Walking the init table
		Ready, // Waiting on the host
		WriteHigh, // Data high nibble
		WriteLow // Data low nibble
	} lcdStateT;

	// Source of the nibble on the bus
	typedef enum logic [1:0]
	{
		Rom, // Init table entry
		High, // Held byte, upper half
		Low // Held byte, lower half
	} lcdNibbleSelT;

	////////////////////
	// Host byte, seen whole or as two nibbles
	typedef struct packed
	{
		logic [3:0] high; // Sent first
		logic [3:0] low; // Sent second
	} lcdNibblesT;

	typedef union packed
	{
		logic [7:0] whole; // Host view
		lcdNibblesT nibbles; // Bus view
	} lcdByteU;

endpackage

`default_nettype wire

//--- src/lcdInitRom.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcdTiming_defs.svh"

module lcdInitRom
(
	input wire [`LCD_STEP_WIDTH-1:0] stepIndex, // Table address
	output logic [3:0] romNibble, // Nibble for DB7..DB4
	output logic romPulse, // Step strobes enable
	output logic [`LCD_TIMER_WIDTH-1:0] romLength, // Whole step length
	output logic romLast // Final init step
);

	assign romLast = (stepIndex == `LCD_INIT_STEPS - 1); // Clear low nibble

	always_comb
	begin
		romPulse = 1'b1; // Everything but step 0 writes
		romNibble = 4'h0;
		romLength = `LCD_TIMER_WIDTH'(`LCD_NIBBLE_GAP_CYCLES);
		case (stepIndex)
			// Power-up settle, bus idle
			4'd0:
			begin
				romPulse = 1'b0;
				romLength = `LCD_TIMER_WIDTH'(`LCD_POWERUP_CYCLES);
			end
			////////////////////
			// Wake-up, 8-bit mode nibbles
			4'd1:
			begin
				romNibble = 4'h3;
				romLength = `LCD_TIMER_WIDTH'(`LCD_INIT_WAIT1_CYCLES);
			end
			4'd2:
			begin
				romNibble = 4'h3;
				romLength = `LCD_TIMER_WIDTH'(`LCD_INIT_WAIT2_CYCLES);
			end
			4'd3:
			begin
				romNibble = 4'h3;
				romLength = `LCD_TIMER_WIDTH'(`LCD_INIT_WAIT3_CYCLES);
			end
			4'd4:
			begin
				romNibble = 4'h2; // Switch to 4-bit
				romLength = `LCD_TIMER_WIDTH'(`LCD_INIT_WAIT3_CYCLES);
			end
			////////////////////
			// Configuration, high nibbles keep the gap default
			4'd5: romNibble = 4'h2; // Function set 28h
			4'd6:
			begin
				romNibble = 4'h8;
				romLength = `LCD_TIMER_WIDTH'(`LCD_CMD_CYCLES);
			end
			4'd7: romNibble = 4'h0; // Entry mode 06h
			4'd8:
			begin
				romNibble = 4'h6;
				romLength = `LCD_TIMER_WIDTH'(`LCD_CMD_CYCLES);
			end
			4'd9: romNibble = 4'h0; // Display on 0Ch
			4'd10:
			begin
				romNibble = 4'hC;
				romLength = `LCD_TIMER_WIDTH'(`LCD_CMD_CYCLES);
			end
			4'd11: romNibble = 4'h0; // Clear 01h
			4'd12:
			begin
				romNibble = 4'h1;
				romLength = `LCD_TIMER_WIDTH'(`LCD_SLOW_CYCLES); // Clear is slow
			end
			default: romPulse = 1'b0; // Unreached
		endcase
	end

endmodule

`default_nettype wire

//--- src/lcdStepTimer.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcdTiming_defs.svh"

module lcdStepTimer
(
	input wire Clock,
	input wire rstN,
	input wire stepStart, // Begin a new step
	input wire [`LCD_TIMER_WIDTH-1:0] stepLength, // Whole step, in cycles
	input wire stepPulse, // Step carries an enable pulse
	output logic stepDone, // Last cycle of the step
	output logic pulseActive // Enable window
);

	logic [`LCD_TIMER_WIDTH-1:0] count; // Cycles elapsed in the step
	logic [`LCD_TIMER_WIDTH-1:0] lengthReg; // Captured at start
	logic running;
	logic pulseReq; // Captured at start

	////////////////////
	// Compare stage
	assign stepDone = running && (count == lengthReg - 1'b1); // Count runs 0..len-1
	assign pulseActive = running && pulseReq
		&& (count < `LCD_TIMER_WIDTH'(`LCD_PULSE_CYCLES)); // Front of the step

	////////////////////
	// Counter
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			count <= '0;
		end
		else if (stepStart)
		begin
			running <= 1'b1;
			count <= '0; // First cycle of the step
		end
		else if (stepDone)
			running <= 1'b0; // Idle until the next kick
		else if (running)
			count <= count + 1'b1;
	end

	// Step parameters
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			lengthReg <= '0;
			pulseReq <= 1'b0;
		end
		else if (stepStart)
		begin
			lengthReg <= stepLength;
			pulseReq <= stepPulse;
		end
	end

	// Sequencer waits for each step to finish before the next kick
	assert property (@(posedge Clock) disable iff (!rstN) stepStart |-> !running);
	// Count never runs past the stored length
	assert property (@(posedge Clock) disable iff (!rstN) running |-> count < lengthReg);

endmodule

`default_nettype wire

//--- src/lcdSequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcdTiming_defs.svh"

module lcdSequencer import lcdPkg::*;
(
	input wire Clock,
	input wire rstN,
	input wire dataValid, // Host strobe
	input wire stepDone, // From the timer
	input wire romPulse, // Current table entry
	input wire [`LCD_TIMER_WIDTH-1:0] romLength,
	input wire romLast,
	output logic [`LCD_STEP_WIDTH-1:0] stepIndex, // Table address
	output logic stepStart, // One-cycle kick
	output logic [`LCD_TIMER_WIDTH-1:0] stepLength,
	output logic stepPulse,
	output lcdNibbleSelT nibbleSel, // Source of the bus nibble
	output logic registerSelect,
	output logic byteLoad, // Latch dataIn this edge
	output logic readyForData
);

	lcdStateT state;
	logic stepBusy; // Timer owns the current step

	////////////////////
	// Step request
	assign stepStart = (state != Ready) && !stepBusy; // Once per step, after the handoff
	assign byteLoad = readyForData && dataValid; // Handshake accept

	// Step shape and bus source per state
	always_comb
	begin
		stepLength = `LCD_TIMER_WIDTH'(`LCD_SLOW_CYCLES); // Data low nibble
		stepPulse = 1'b1; // Every data nibble strobes E
		nibbleSel = Low;
		registerSelect = 1'b1; // Data register
		case (state)
			Init:
			begin
				stepLength = romLength;
				stepPulse = romPulse;
				nibbleSel = Rom;
				registerSelect = 1'b0; // Commands only
			end
			WriteHigh:
			begin
				stepLength = `LCD_TIMER_WIDTH'(`LCD_NIBBLE_GAP_CYCLES);
				nibbleSel = High;
			end
			default:
				stepPulse = 1'b1; // WriteLow, Ready starts no step
		endcase
	end

	////////////////////
	// FSM
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= Init;
			stepIndex <= '0;
			stepBusy <= 1'b0;
			readyForData <= 1'b0;
		end
		else
		begin
			if (stepStart)
				stepBusy <= 1'b1;
			else if (stepDone)
				stepBusy <= 1'b0; // Next kick one cycle later
			case (state)
				Init:
				begin
					if (stepDone)
					begin
						if (romLast)
						begin
							state <= Ready;
							readyForData <= 1'b1;
						end
						else
							stepIndex <= stepIndex + 1'b1;
					end
				end
				Ready:
				begin
					if (byteLoad)
					begin
						state <= WriteHigh;
						readyForData <= 1'b0; // One byte in flight
					end
				end
				WriteHigh:
				begin
					if (stepDone)
						state <= WriteLow;
				end
				WriteLow:
				begin
					if (stepDone)
					begin
						state <= Ready;
						readyForData <= 1'b1;
					end
				end
			endcase
		end
	end

	// Host only offered the bus between steps
	assert property (@(posedge Clock) disable iff (!rstN)
		readyForData |-> !stepBusy && !stepDone);

endmodule

`default_nettype wire

//--- src/lcdBusDriver.sv
`timescale 1ns/100ps
`default_nettype none

module lcdBusDriver import lcdPkg::*;
(
	input wire Clock,
	input wire rstN,
	input wire lcdByteU dataIn, // Host byte
	input wire byteLoad, // Accept edge
	input wire lcdNibbleSelT nibbleSel,
	input wire [3:0] romNibble,
	input wire registerSelect,
	input wire pulseActive, // Enable window from the timer
	output logic lcdEnable,
	output logic lcdRegisterSelect,
	output logic [3:0] lcdData
);

	lcdByteU heldByte; // Byte being written
	logic [3:0] nibble; // Selected source

	// Capture on the handshake
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
			heldByte.whole <= 8'h00;
		else if (byteLoad)
			heldByte.whole <= dataIn.whole;
	end

	////////////////////
	// Nibble select
	always_comb
	begin
		case (nibbleSel)
			High: nibble = heldByte.nibbles.high; // Sent first
			Low: nibble = heldByte.nibbles.low;
			default: nibble = romNibble; // Init table
		endcase
	end

	////////////////////
	// Output flops, one cycle behind the control
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			lcdEnable <= 1'b0;
			lcdRegisterSelect <= 1'b0;
			lcdData <= 4'h0;
		end
		else
		begin
			lcdEnable <= pulseActive; // Lags data by a cycle at the rise
			lcdRegisterSelect <= registerSelect;
			lcdData <= nibble;
		end
	end

	// Bus held from the rise of E until a cycle after its fall
	assert property (@(posedge Clock) disable iff (!rstN)
		(lcdEnable || $past(lcdEnable)) |-> $stable(lcdData) && $stable(lcdRegisterSelect));

endmodule

`default_nettype wire

//--- src/lcdController.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcdTiming_defs.svh"

module lcdController import lcdPkg::*;
(
	input wire Clock,
	input wire rstN,
	input wire lcdByteU dataIn, // Character or raw byte
	input wire dataValid, // Host offers a byte
	output logic readyForData, // Controller idle
	output logic lcdEnable, // E strobe
	output logic lcdRegisterSelect, // 0 command, 1 data
	output logic [3:0] lcdData // DB7..DB4
);

	logic stepStart; // Sequencer kicks the timer
	logic [`LCD_TIMER_WIDTH-1:0] stepLength;
	logic stepPulse;
	logic stepDone; // Last cycle of a step
	logic pulseActive; // Enable window
	logic [`LCD_STEP_WIDTH-1:0] stepIndex;
	logic [3:0] romNibble;
	logic romPulse;
	logic [`LCD_TIMER_WIDTH-1:0] romLength;
	logic romLast;
	lcdNibbleSelT nibbleSel;
	logic registerSelect;
	logic byteLoad; // Handshake accept

	////////////////////
	// Control
	lcdSequencer seq0
	(
		.Clock(Clock),
		.rstN(rstN),
		.dataValid(dataValid),
		.stepDone(stepDone),
		.romPulse(romPulse),
		.romLength(romLength),
		.romLast(romLast),
		.stepIndex(stepIndex),
		.stepStart(stepStart),
		.stepLength(stepLength),
		.stepPulse(stepPulse),
		.nibbleSel(nibbleSel),
		.registerSelect(registerSelect),
		.byteLoad(byteLoad),
		.readyForData(readyForData)
	);

	lcdStepTimer timer0
	(
		.Clock(Clock),
		.rstN(rstN),
		.stepStart(stepStart),
		.stepLength(stepLength),
		.stepPulse(stepPulse),
		.stepDone(stepDone),
		.pulseActive(pulseActive)
	);

	lcdInitRom rom0
	(
		.stepIndex(stepIndex),
		.romNibble(romNibble),
		.romPulse(romPulse),
		.romLength(romLength),
		.romLast(romLast)
	);

	////////////////////
	// Pins
	lcdBusDriver driver0
	(
		.Clock(Clock),
		.rstN(rstN),
		.dataIn(dataIn),
		.byteLoad(byteLoad),
		.nibbleSel(nibbleSel),
		.romNibble(romNibble),
		.registerSelect(registerSelect),
		.pulseActive(pulseActive),
		.lcdEnable(lcdEnable),
		.lcdRegisterSelect(lcdRegisterSelect),
		.lcdData(lcdData)
	);

endmodule

`default_nettype wire

//--- sim/lcdBusMonitor.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcdTiming_defs.svh"

module lcdBusMonitor
(
	input wire Clock,
	input wire rstN,
	input wire [7:0] dataIn, // Host byte, used for labels
	input wire dataValid,
	input wire readyForData,
	input wire lcdEnable,
	input wire lcdRegisterSelect,
	input wire [3:0] lcdData,
	output logic [31:0] errorCount
);

	logic [3:0] expNibble[$]; // Expected bus writes, in order
	logic expRs[$];
	int expLength[$]; // Step length that follows each write

	logic prevEnable;
	logic prevReady;
	logic prevRs;
	logic [3:0] prevData;
	int cycle; // Edges since reset release
	int resetEdges;
	int riseCycle; // Last enable rise
	int riseCount;
	int lastLength; // Min spacing owed by the last nibble
	int seenNibbles;
	bit initDone;
	bit inWrite; // Byte accepted, not yet finished
	bit acceptPending;
	int writeRises;
	int lowRiseCycle;
	logic [7:0] currentByte;
	int testNumber;
	int testsPassed;
	int testsFailed;
	logic [31:0] testStartErrors;

	task automatic pushNibble(input logic [3:0] nib, input logic rs, input int len);
		expNibble.push_back(nib);
		expRs.push_back(rs);
		expLength.push_back(len);
	endtask

	// Data byte goes out high nibble first
	task automatic expectByte(input logic [7:0] value);
		pushNibble(value[7:4], 1'b1, `LCD_NIBBLE_GAP_CYCLES);
		pushNibble(value[3:0], 1'b1, `LCD_SLOW_CYCLES);
	endtask

	task automatic reportFail(input string msg);
		$display("FAIL %0t ns: %s", $time, msg);
		errorCount = errorCount + 1;
	endtask

	task automatic checkIdle(input string when);
		if (lcdEnable !== 1'b0 || readyForData !== 1'b0 || lcdRegisterSelect !== 1'b0
			|| lcdData !== 4'h0)
			reportFail($sformatf("outputs not idle %s, E=%b RS=%b D=%h ready=%b", when,
				lcdEnable, lcdRegisterSelect, lcdData, readyForData));
	endtask

	task automatic endTest(input string label);
		testNumber++;
		if (errorCount == testStartErrors)
			testsPassed++;
		else
			testsFailed++;
		$display("test %0d %s: %s", testNumber, label,
			(errorCount == testStartErrors) ? "pass" : "fail");
		testStartErrors = errorCount;
	endtask

	// Written at a falling enable
	task automatic captureNibble(input logic [3:0] nib, input logic rs);
		seenNibbles++;
		if (expNibble.size() == 0)
		begin
			reportFail($sformatf("nibble %h RS %b written with nothing expected", nib, rs));
			lastLength = 0;
		end
		else
		begin
			if (nib !== expNibble[0] || rs !== expRs[0])
				reportFail($sformatf("nibble %h RS %b, expected %h RS %b", nib, rs,
					expNibble[0], expRs[0]));
			lastLength = expLength[0];
			void'(expNibble.pop_front());
			void'(expRs.pop_front());
			void'(expLength.pop_front());
		end
	endtask

	task automatic readyRose();
		if (!initDone)
		begin
			if (seenNibbles != 12)
				reportFail($sformatf("ready after %0d of 12 init nibbles", seenNibbles));
			initDone = 1'b1;
			endTest("init sequence");
		end
		else if (inWrite)
		begin
			if (writeRises != 2)
				reportFail($sformatf("byte %h gave %0d enable pulses", currentByte, writeRises));
			else if (cycle - lowRiseCycle < `LCD_SLOW_CYCLES - 1) // E lags step start by one
				reportFail($sformatf("ready %0d cycles after low nibble", cycle - lowRiseCycle));
			inWrite = 1'b0;
			endTest($sformatf("byte %02h", currentByte));
		end
		else
			reportFail("readyForData rose with no write in progress");
	endtask

	task automatic reportCounts();
		if (expNibble.size() != 0)
		begin
			$display("Run ended with %0d expected nibbles never written", expNibble.size());
			errorCount = errorCount + 1;
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d", testNumber, testsPassed,
			testsFailed, errorCount);
	endtask

	initial
	begin
		errorCount = 0;
		resetEdges = 0;
		riseCount = 0;
		seenNibbles = 0;
		testNumber = 0;
		testsPassed = 0;
		testsFailed = 0;
		testStartErrors = 0;
		// Wake-up nibbles
		pushNibble(4'h3, 1'b0, `LCD_INIT_WAIT1_CYCLES);
		pushNibble(4'h3, 1'b0, `LCD_INIT_WAIT2_CYCLES);
		pushNibble(4'h3, 1'b0, `LCD_INIT_WAIT3_CYCLES);
		pushNibble(4'h2, 1'b0, `LCD_INIT_WAIT3_CYCLES);
		// Config 28h, 06h, 0Ch, 01h
		pushNibble(4'h2, 1'b0, `LCD_NIBBLE_GAP_CYCLES);
		pushNibble(4'h8, 1'b0, `LCD_CMD_CYCLES);
		pushNibble(4'h0, 1'b0, `LCD_NIBBLE_GAP_CYCLES);
		pushNibble(4'h6, 1'b0, `LCD_CMD_CYCLES);
		pushNibble(4'h0, 1'b0, `LCD_NIBBLE_GAP_CYCLES);
		pushNibble(4'hC, 1'b0, `LCD_CMD_CYCLES);
		pushNibble(4'h0, 1'b0, `LCD_NIBBLE_GAP_CYCLES);
		pushNibble(4'h1, 1'b0, `LCD_SLOW_CYCLES); // Clear is slow
	end

	////////////////////
	// Samples are the values held over the cycle before each edge
	always @(posedge Clock)
	begin
		if (!rstN)
		begin
			if (resetEdges > 0)
				checkIdle("during reset");
			resetEdges++;
			cycle = 0;
			prevEnable = 1'b0;
			prevReady = 1'b0;
			acceptPending = 1'b0;
		end
		else
		begin
			if (cycle == 0)
				checkIdle("right after reset");
			cycle++;
			// Enable rise, spacing from the previous write
			if (lcdEnable === 1'b1 && prevEnable !== 1'b1)
			begin
				if (riseCount > 0 && cycle - riseCycle < lastLength)
					reportFail($sformatf("enable rise %0d cycles after previous, needs %0d",
						cycle - riseCycle, lastLength));
				riseCycle = cycle;
				riseCount++;
				if (inWrite)
				begin
					writeRises++;
					if (writeRises == 2)
						lowRiseCycle = cycle;
				end
			end
			if (lcdEnable === 1'b1 && prevEnable === 1'b1
				&& (lcdData !== prevData || lcdRegisterSelect !== prevRs))
				reportFail("bus changed while enable high");
			// Fall, bus must still hold for this cycle
			if (lcdEnable !== 1'b1 && prevEnable === 1'b1)
			begin
				if (cycle - riseCycle != `LCD_PULSE_CYCLES)
					reportFail($sformatf("enable high %0d cycles", cycle - riseCycle));
				if (lcdData !== prevData || lcdRegisterSelect !== prevRs)
					reportFail("bus changed in the cycle after enable fell");
				captureNibble(prevData, prevRs);
			end
			// Handshake
			if (acceptPending)
			begin
				if (readyForData !== 1'b0)
					reportFail("readyForData still high the cycle after acceptance");
				acceptPending = 1'b0;
			end
			if (readyForData === 1'b1 && prevReady !== 1'b1)
				readyRose();
			if (readyForData === 1'b1 && dataValid === 1'b1)
			begin
				acceptPending = 1'b1;
				inWrite = 1'b1;
				writeRises = 0;
				currentByte = dataIn;
			end
			prevEnable = lcdEnable;
			prevReady = readyForData;
		end
		prevData = lcdData;
		prevRs = lcdRegisterSelect;
	end

endmodule

`default_nettype wire

//--- sim/lcdControllerTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcdTiming_defs.svh"

module lcdControllerTb import lcdPkg::*;
();

	localparam int entryCount = 6;

	logic Clock;
	logic rstN;
	lcdByteU dataIn;
	logic dataValid;
	logic readyForData;
	logic lcdEnable;
	logic lcdRegisterSelect;
	logic [3:0] lcdData;
	logic [31:0] errorCount; // From the monitor

	////////////////////
	// Stimulus table
	logic [7:0] byteTable [entryCount];
	int gapTable [entryCount]; // Idle cycles before the strobe
	bit spurTable [entryCount]; // Extra strobe while busy
	longint cycleCount;
	longint cycleLimit;
	int entry;

	initial
		Clock = 1'b0;
	always
		#20 Clock = ~Clock; // 40 ns period

	lcdController dut0
	(
		.Clock(Clock),
		.rstN(rstN),
		.dataIn(dataIn),
		.dataValid(dataValid),
		.readyForData(readyForData),
		.lcdEnable(lcdEnable),
		.lcdRegisterSelect(lcdRegisterSelect),
		.lcdData(lcdData)
	);

	lcdBusMonitor mon0
	(
		.Clock(Clock),
		.rstN(rstN),
		.dataIn(dataIn),
		.dataValid(dataValid),
		.readyForData(readyForData),
		.lcdEnable(lcdEnable),
		.lcdRegisterSelect(lcdRegisterSelect),
		.lcdData(lcdData),
		.errorCount(errorCount)
	);

	task automatic setEntry(input int idx, input logic [7:0] value, input int gap, input bit spur);
		byteTable[idx] = value;
		gapTable[idx] = gap;
		spurTable[idx] = spur;
	endtask

	task automatic waitReady();
		while (readyForData !== 1'b1)
			@(negedge Clock);
	endtask

	// Guard against a stuck DUT
	always @(posedge Clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run still going after %0d cycles", cycleCount);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		rstN = 1'b0;
		dataValid = 1'b0;
		dataIn.whole = 8'h00;
		cycleCount = 0;
		void'($urandom(32'hae8e));
		setEntry(0, 8'h41, 0, 1'b0); // 'A', back to back
		setEntry(1, 8'h00, 5, 1'b1);
		setEntry(2, 8'hFF, $urandom % 30, 1'b0);
		setEntry(3, 8'hA5, 1, 1'b1);
		setEntry(4, 8'h3C, $urandom % 30, 1'b0);
		setEntry(5, 8'h96, $urandom % 30, 1'b1);
		// All ROM steps, then each entry, doubled
		cycleLimit = `LCD_POWERUP_CYCLES + `LCD_INIT_WAIT1_CYCLES + `LCD_INIT_WAIT2_CYCLES
			+ 2 * `LCD_INIT_WAIT3_CYCLES + 4 * `LCD_NIBBLE_GAP_CYCLES + 3 * `LCD_CMD_CYCLES
			+ `LCD_SLOW_CYCLES;
		for (entry = 0; entry < entryCount; entry++)
			cycleLimit += gapTable[entry] + `LCD_NIBBLE_GAP_CYCLES + `LCD_SLOW_CYCLES + 100;
		cycleLimit = 2 * cycleLimit;
		repeat (16) @(negedge Clock);
		rstN = 1'b1;
		////////////////////
		// Apply the table
		for (entry = 0; entry < entryCount; entry++)
		begin
			waitReady();
			repeat (gapTable[entry]) @(negedge Clock);
			dataIn.whole = byteTable[entry];
			dataValid = 1'b1;
			mon0.expectByte(byteTable[entry]);
			@(negedge Clock);
			dataValid = 1'b0;
			dataIn.whole = ~byteTable[entry]; // Byte only valid with the strobe
			if (spurTable[entry])
			begin
				repeat (3) @(negedge Clock);
				dataIn.whole = 8'h5A;
				dataValid = 1'b1; // Must be ignored
				@(negedge Clock);
				dataValid = 1'b0;
			end
			while (readyForData === 1'b1)
				@(negedge Clock);
		end
		waitReady();
		repeat (2) @(negedge Clock);
		mon0.reportCounts();
		@(negedge Clock);
		if (errorCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
src/lcdPkg.sv
src/lcdInitRom.sv
src/lcdStepTimer.sv
src/lcdSequencer.sv
src/lcdBusDriver.sv
src/lcdController.sv
sim/lcdBusMonitor.sv
sim/lcdControllerTb.sv
